// File: hdl/addr_dependency_table.sv
/* address dependency table
   circular buffer of pending store ranges, checked against the two
   operand addresses of the next instruction */
module addr_dependency_table (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                push,
    input  logic [31:0]         push_addr,
    input  mem_read_pkg::size_t push_size,
    input  logic                pop,
    input  logic [31:0]         cmp0_addr,
    input  logic [31:0]         cmp1_addr,
    input  mem_read_pkg::size_t cmp_size,
    output logic                hit0,
    output logic                hit1,
    output logic                full
);
    import mem_read_pkg::*;

    logic [31:0]          ent_addr [DEP_DEPTH];
    size_t                ent_size [DEP_DEPTH];
    logic [DEP_PTR_W-1:0] head;             // oldest entry
    logic [DEP_PTR_W-1:0] tail;             // next free slot
    logic [DEP_CNT_W-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    // half-open byte ranges [a, a+la) and [b, b+lb) intersect
    function automatic logic overlap(input logic [31:0] a, input size_t sa,
                                     input logic [31:0] b, input size_t sb);
        logic [32:0] a_end;
        logic [32:0] b_end;
        a_end = {1'b0, a} + 33'(size_bytes(sa));   // no wrap past 4G
        b_end = {1'b0, b} + 33'(size_bytes(sb));
        return (size_bytes(sa) != 4'd0) && (size_bytes(sb) != 4'd0) &&
               ({1'b0, a} < b_end) && ({1'b0, b} < a_end);
    endfunction

    assign full    = (count == DEP_CNT_W'(DEP_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);   // empty pop ignored

    always_comb begin
        logic [DEP_PTR_W-1:0] offs;
        hit0 = 1'b0;
        hit1 = 1'b0;
        for (int i = 0; i < DEP_DEPTH; i++) begin
            offs = DEP_PTR_W'(i) - head;     // age of slot i
            if ({1'b0, offs} < count) begin
                hit0 |= overlap(cmp0_addr, cmp_size, ent_addr[i], ent_size[i]);
                hit1 |= overlap(cmp1_addr, cmp_size, ent_addr[i], ent_size[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;                    // all pending stores dropped
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) tail <= tail + 1'b1;
            if (do_pop) head <= head + 1'b1;
            count <= count + DEP_CNT_W'(do_push) - DEP_CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            ent_addr[tail] <= push_addr;
            ent_size[tail] <= push_size;
        end
    end

endmodule

// File: hdl/dcache_read_port.sv
/* data cache read sequencer
   reads op0 then op1 when flagged as addresses, keeps both words
   until the stage consumes the item */
module dcache_read_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  start,
    input  mem_read_pkg::mr_req_t req,
    input  logic                  consume,
    output logic                  rd_done,
    output logic [63:0]           data0,
    output logic [63:0]           data1,
    output logic                  rd_req_valid,
    input  logic                  rd_req_ready,
    output logic [31:0]           rd_req_address,
    input  logic                  rd_dp_valid,
    output logic                  rd_dp_ready,
    input  logic [63:0]           rd_dp_read_data
);

    typedef enum logic [2:0] {
        IDLE,
        REQ0,                               // op0 request out
        WAIT0,                              // op0 response pending
        REQ1,
        WAIT1,
        DONE,                               // words held for consume
        DRAIN                               // flushed, toss the response
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   req_hs;
    logic   rsp_hs;
    logic   no_reads;

    assign req_hs   = rd_req_valid && rd_req_ready;
    assign rsp_hs   = rd_dp_valid && rd_dp_ready;
    assign no_reads = !req.op0_is_address && !req.op1_is_address;

    assign rd_req_valid   = (state == REQ0) || (state == REQ1);
    assign rd_req_address = (state == REQ1) ? req.op1.address.addr : req.op0.address.addr;
    assign rd_dp_ready    = 1'b1;           // responses always sink

    // register-only items finish right away
    assign rd_done = (state == DONE) || ((state == IDLE) && start && no_reads);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start && !flush) begin
                    if (req.op0_is_address) begin
                        state_nxt = REQ0;
                    end else if (req.op1_is_address) begin
                        state_nxt = REQ1;       // skip op0 states
                    end
                end
            end
            REQ0: begin
                if (req_hs) begin
                    state_nxt = flush ? DRAIN : WAIT0;
                end else if (flush) begin
                    state_nxt = IDLE;           // nothing issued yet
                end
            end
            WAIT0: begin
                if (rsp_hs) begin
                    if (flush) begin
                        state_nxt = IDLE;
                    end else begin
                        state_nxt = req.op1_is_address ? REQ1 : DONE;
                    end
                end else if (flush) begin
                    state_nxt = DRAIN;
                end
            end
            REQ1: begin
                if (req_hs) begin
                    state_nxt = flush ? DRAIN : WAIT1;
                end else if (flush) begin
                    state_nxt = IDLE;
                end
            end
            WAIT1: begin
                if (rsp_hs) begin
                    state_nxt = flush ? IDLE : DONE;
                end else if (flush) begin
                    state_nxt = DRAIN;
                end
            end
            DONE:    if (consume || flush) state_nxt = IDLE;
            DRAIN:   if (rsp_hs) state_nxt = IDLE;  // in-order, this is ours
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture read words, untouched until the next read
    always_ff @(posedge clk) begin
        if ((state == WAIT0) && rsp_hs) begin
            data0 <= rd_dp_read_data;
        end
        if ((state == WAIT1) && rsp_hs) begin
            data1 <= rd_dp_read_data;
        end
    end

endmodule

// File: hdl/mem_read_data_mask.sv
/* read data mask
   keeps the low bytes of the cache word that the operand size covers */
module mem_read_data_mask (
    input  logic [63:0]         data,
    input  mem_read_pkg::size_t size,
    output logic [63:0]         masked
);
    import mem_read_pkg::*;

    logic [3:0] nbytes;                     // 0 for none and bad codes

    assign nbytes = size_bytes(size);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            // zero extend above the operand
            masked[i*8 +: 8] = (i < nbytes) ? data[i*8 +: 8] : 8'h00;
        end
    end

endmodule

// File: hdl/mem_read_pipestage.sv
/* memory read to execute pipestage
   one entry valid/ready slice, full throughput */
module mem_read_pipestage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  mem_read_pkg::mr_exe_t in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output mem_read_pkg::mr_exe_t out_data
);
    import mem_read_pkg::*;

    logic    valid_q;
    mr_exe_t data_q;                        // payload, no reset

    // take a new item when empty or when the current one leaves
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;                // drop whatever is held
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;              // holds while out_ready low
        end
    end

endmodule

// File: hdl/mem_read_pkg.sv
/* memory read stage definitions
   size codes, dependency table sizing, the operand word and the
   payloads passed from the address stage and on to execute */
package mem_read_pkg;

    typedef logic [2:0] size_t;             // operand size code from decode

    localparam size_t SIZE_NONE = 3'd0;
    localparam size_t SIZE_8    = 3'd1;
    localparam size_t SIZE_16   = 3'd2;
    localparam size_t SIZE_32   = 3'd3;
    localparam size_t SIZE_48   = 3'd4;
    localparam size_t SIZE_64   = 3'd5;     // 6 and 7 unused, read as zero

    localparam int DEP_DEPTH = 4;           // pending store entries
    localparam int DEP_PTR_W = $clog2(DEP_DEPTH);
    localparam int DEP_CNT_W = DEP_PTR_W + 1;   // count reaches DEP_DEPTH

    // address view of an operand word
    typedef struct packed {
        logic [31:0] upper;
        logic [31:0] addr;                  // linear address
    } op_addr_t;

    typedef union packed {
        logic [63:0] value;                 // register value
        op_addr_t    address;               // same bits seen as address
    } operand_u;

    // instruction from the address stage
    typedef struct packed {
        size_t       size;
        logic        set_d_flag;
        logic        clear_d_flag;
        operand_u    op0;
        operand_u    op1;
        logic [2:0]  op0_reg;
        logic [2:0]  op1_reg;
        logic        op0_is_address;
        logic        op1_is_address;
        logic [47:0] imm;
        logic [3:0]  alu_op;
        logic [2:0]  flag_0;
        logic [2:0]  flag_1;
        logic [31:0] pc;
        logic        branch_taken;
        logic        to_sys_controller;
        logic [15:0] opcode;
    } mr_req_t;

    // payload toward execute
    typedef struct packed {
        size_t       size;
        logic        set_d_flag;
        logic        clear_d_flag;
        logic [63:0] op_a;                  // memory or register value
        logic [63:0] op_b;
        logic [2:0]  op_a_reg;
        logic [31:0] op_a_address;          // destination if op a is memory
        logic        op_a_is_address;
        logic [47:0] imm;
        logic [3:0]  alu_op;
        logic [2:0]  flag_0;
        logic [2:0]  flag_1;
        logic [31:0] pc;
        logic        branch_taken;
        logic        to_sys_controller;
        logic [15:0] opcode;
    } mr_exe_t;

    // byte count covered by a size code
    function automatic logic [3:0] size_bytes(input size_t size);
        case (size)
            SIZE_NONE: return 4'd0;
            SIZE_8:    return 4'd1;
            SIZE_16:   return 4'd2;
            SIZE_32:   return 4'd4;
            SIZE_48:   return 4'd6;
            SIZE_64:   return 4'd8;
            default:   return 4'd0;         // invalid codes
        endcase
    endfunction

endpackage

// File: hdl/memory_read_top.sv
/* memory read stage
   reads memory operands, masks them to size, holds on pending stores
   and registers the result toward execute */
module memory_read_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  wb_valid,
    input  logic                  wb_ready,
    input  logic                  wb_to_memory,
    input  logic                  a_valid,
    output logic                  a_ready,
    input  mem_read_pkg::mr_req_t a_req,
    output logic                  e_valid,
    input  logic                  e_ready,
    output mem_read_pkg::mr_exe_t e_data,
    output logic                  rd_req_valid,
    input  logic                  rd_req_ready,
    output logic [31:0]           rd_req_address,
    input  logic                  rd_dp_valid,
    input  logic [63:0]           rd_dp_read_data,
    output logic                  rd_dp_ready
);
    import mem_read_pkg::*;

    logic        halt;
    logic        rd_start;
    logic        rd_done;
    logic        p_valid;
    logic        p_ready;
    logic        push;
    logic        pop;
    logic        hit0;
    logic        hit1;
    logic        tbl_full;
    logic [63:0] data0;
    logic [63:0] data1;
    logic [63:0] data0_m;
    logic [63:0] data1_m;
    mr_exe_t     p_data;

    // hold while an address operand touches a pending store
    assign halt = (hit0 && a_req.op0_is_address) ||
                  (hit1 && a_req.op1_is_address) ||
                  (a_req.op0_is_address && tbl_full);   // no room for our store

    assign rd_start = a_valid && !halt;     // no reading ahead of a store
    assign p_valid  = a_valid && rd_done && !halt;
    assign a_ready  = p_valid && p_ready;
    assign push     = a_ready && a_req.op0_is_address;  // at acceptance
    assign pop      = wb_valid && wb_ready && wb_to_memory;

    dcache_read_port u_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .start           (rd_start),
        .req             (a_req),
        .consume         (a_ready),
        .rd_done         (rd_done),
        .data0           (data0),
        .data1           (data1),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .rd_req_address  (rd_req_address),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_ready     (rd_dp_ready),
        .rd_dp_read_data (rd_dp_read_data)
    );

    mem_read_data_mask u_mask0 (.data(data0), .size(a_req.size), .masked(data0_m));
    mem_read_data_mask u_mask1 (.data(data1), .size(a_req.size), .masked(data1_m));

    addr_dependency_table u_dep (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push      (push),
        .push_addr (a_req.op0.address.addr),
        .push_size (a_req.size),
        .pop       (pop),
        .cmp0_addr (a_req.op0.address.addr),
        .cmp1_addr (a_req.op1.address.addr),
        .cmp_size  (a_req.size),
        .hit0      (hit0),
        .hit1      (hit1),
        .full      (tbl_full)
    );

    // execute payload
    always_comb begin
        p_data.size              = a_req.size;
        p_data.set_d_flag        = a_req.set_d_flag;
        p_data.clear_d_flag      = a_req.clear_d_flag;
        p_data.op_a              = a_req.op0_is_address ? data0_m : a_req.op0.value;
        p_data.op_b              = a_req.op1_is_address ? data1_m : a_req.op1.value;
        p_data.op_a_reg          = a_req.op0_reg;
        p_data.op_a_address      = a_req.op0.address.addr;  // store target
        p_data.op_a_is_address   = a_req.op0_is_address;
        p_data.imm               = a_req.imm;
        p_data.alu_op            = a_req.alu_op;
        p_data.flag_0            = a_req.flag_0;
        p_data.flag_1            = a_req.flag_1;
        p_data.pc                = a_req.pc;
        p_data.branch_taken      = a_req.branch_taken;
        p_data.to_sys_controller = a_req.to_sys_controller;
        p_data.opcode            = a_req.opcode;
    end

    mem_read_pipestage u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (p_valid),
        .in_ready  (p_ready),
        .in_data   (p_data),
        .out_valid (e_valid),
        .out_ready (e_ready),
        .out_data  (e_data)
    );

endmodule

// File: memory_read_top.f
hdl/mem_read_pkg.sv
hdl/mem_read_pipestage.sv
hdl/dcache_read_port.sv
hdl/mem_read_data_mask.sv
hdl/addr_dependency_table.sv
hdl/memory_read_top.sv
sim/tb_dcache_model.sv
sim/tb_memory_read_top.sv

// File: sim/tb_dcache_model.sv
/* behavioral data cache for the read port
   answers reads in order after 0 to 3 idle cycles, data is the
   request address followed by its inverse */
module tb_dcache_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] req_address,
    output logic        dp_valid,
    input  logic        dp_ready,
    output logic [63:0] dp_read_data
);
    logic [31:0] pending [$];               // accepted, not yet answered
    logic [31:0] req_addr_s;
    logic        req_hs;
    logic        rsp_hs;
    logic        in_reset;
    int          delay;                     // idle cycles before next answer

    initial begin
        req_ready    = 1'b1;                // requests never stall
        dp_valid     = 1'b0;
        dp_read_data = '0;
        delay        = 0;
    end

    always @(posedge clk) begin
        req_hs     = req_valid && req_ready;    // values from before the edge
        rsp_hs     = dp_valid && dp_ready;
        req_addr_s = req_address;
        in_reset   = !rst_n;
        #1;
        if (in_reset) begin
            pending.delete();
            dp_valid = 1'b0;
        end else begin
            if (rsp_hs) begin
                void'(pending.pop_front());
                dp_valid = 1'b0;
                delay    = int'($urandom % 4);
            end
            if (req_hs) pending.push_back(req_addr_s);
            if (!dp_valid && pending.size() != 0) begin
                if (delay == 0) begin
                    dp_valid     = 1'b1;
                    dp_read_data = {pending[0], ~pending[0]};
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

// File: sim/tb_memory_read_top.sv
/* testbench for the memory read stage
   register and memory items against a cache model, scoreboard on the
   execute side, dependency hold, back-pressure and flush checks */
module tb_memory_read_top;
    import mem_read_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        wb_valid;
    logic        wb_ready;
    logic        wb_to_memory;
    logic        a_valid;
    logic        a_ready;
    mr_req_t     a_req;
    logic        e_valid;
    logic        e_ready;
    mr_exe_t     e_data;
    logic        rd_req_valid;
    logic        rd_req_ready;
    logic [31:0] rd_req_address;
    logic        rd_dp_valid;
    logic        rd_dp_ready;
    logic [63:0] rd_dp_read_data;

    logic        ready_random;              // e_ready with random gaps
    logic        hold_window;               // a_ready must stay low
    logic        last_stall;                // e_valid held without e_ready
    mr_exe_t     last_data;
    mr_exe_t     exp_q [$];                 // accepted and not yet at execute
    string       test_name;

    memory_read_top dut (.*);

    tb_dcache_model u_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (rd_req_valid),
        .req_ready    (rd_req_ready),
        .req_address  (rd_req_address),
        .dp_valid     (rd_dp_valid),
        .dp_ready     (rd_dp_ready),
        .dp_read_data (rd_dp_read_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s: %s", test_name, what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string check, input logic [319:0] exp_v,
                                   input logic [319:0] act_v);
        $display("** Error %s (%s) expected %h actual %h", test_name, check, exp_v, act_v);
        stop_run("value mismatch");
    endtask

    // keep the low bytes the size code covers
    function automatic logic [63:0] mask_to_size(input logic [63:0] word, input size_t size);
        int nbytes;
        nbytes = int'(size_bytes(size));
        if (nbytes >= 8) return word;
        return word & ((64'd1 << (8 * nbytes)) - 64'd1);
    endfunction

    function automatic logic [63:0] cache_word(input logic [31:0] addr);
        return {addr, ~addr};
    endfunction

    function automatic mr_exe_t expected_exe(input mr_req_t r);
        mr_exe_t x;
        x.size              = r.size;
        x.set_d_flag        = r.set_d_flag;
        x.clear_d_flag      = r.clear_d_flag;
        x.op_a              = r.op0_is_address ?
                              mask_to_size(cache_word(r.op0.address.addr), r.size) : r.op0.value;
        x.op_b              = r.op1_is_address ?
                              mask_to_size(cache_word(r.op1.address.addr), r.size) : r.op1.value;
        x.op_a_reg          = r.op0_reg;
        x.op_a_address      = r.op0.value[31:0];    // low half of op0
        x.op_a_is_address   = r.op0_is_address;
        x.imm               = r.imm;
        x.alu_op            = r.alu_op;
        x.flag_0            = r.flag_0;
        x.flag_1            = r.flag_1;
        x.pc                = r.pc;
        x.branch_taken      = r.branch_taken;
        x.to_sys_controller = r.to_sys_controller;
        x.opcode            = r.opcode;
        return x;
    endfunction

    function automatic mr_req_t random_req(input logic addr0, input logic addr1,
                                           input size_t size);
        logic [255:0] bits;
        mr_req_t      r;
        for (int i = 0; i < 8; i++) begin
            bits[i*32 +: 32] = $urandom;
        end
        r                = bits[$bits(mr_req_t)-1:0];
        r.size           = size;
        r.op0_is_address = addr0;
        r.op1_is_address = addr1;
        return r;
    endfunction

    // present one item and hold it until the stage takes it
    task automatic send_item(input mr_req_t req);
        int n;
        n       = 0;
        a_req   = req;
        a_valid = 1'b1;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) stop_run("item never accepted by the stage");
        end while (!a_ready);
        #1;
        a_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) stop_run("accepted items never reached execute");
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (ready_random) e_ready = ($urandom % 4) != 0;   // roughly one gap in four
    end

    always @(posedge clk) begin
        last_stall <= rst_n && e_valid && !e_ready && !flush;
        last_data  <= e_data;
    end

    // compare before the flush drop and push after
    always @(posedge clk) begin
        mr_exe_t want;
        if (rst_n && e_valid && e_ready) begin
            if (exp_q.size() == 0) begin
                stop_run("execute output with no accepted item");
            end else begin
                want = exp_q.pop_front();
                assert (e_data == want)
                    else report_mismatch("scoreboard", 320'(want), 320'(e_data));
            end
        end
        if (flush) exp_q.delete();          // held item is dropped
        if (rst_n && a_valid && a_ready) exp_q.push_back(expected_exe(a_req));
    end

    assert property (@(posedge clk)
        !rst_n |-> !e_valid && !rd_req_valid && !a_ready && rd_dp_ready)
        else stop_run("stage outputs not idle during reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        last_stall |-> e_valid && e_data == last_data)
        else report_mismatch("back-pressure hold", 320'($sampled(last_data)),
                             320'($sampled(e_data)));

    assert property (@(posedge clk) disable iff (!rst_n) flush |=> !e_valid)
        else report_mismatch("flush clears stage", 320'(0), 320'($sampled(e_valid)));

    assert property (@(posedge clk) disable iff (!rst_n)
        e_valid && e_data.op_a_is_address && size_bytes(e_data.size) == 4'd0
        |-> e_data.op_a == 64'd0)
        else report_mismatch("zero size read", 320'(0), 320'($sampled(e_data.op_a)));

    assert property (@(posedge clk) disable iff (!rst_n) hold_window |-> !a_ready)
        else report_mismatch("dependency hold", 320'(0), 320'($sampled(a_ready)));

    initial begin
        mr_req_t item;
        void'($urandom(32'h22f42187));      // fixed seed
        test_name    = "reset";
        rst_n        = 1'b0;
        flush        = 1'b0;
        wb_valid     = 1'b1;                // pops every cycle unless a test stops them
        wb_ready     = 1'b1;
        wb_to_memory = 1'b1;
        a_valid      = 1'b0;
        a_req        = '0;
        e_ready      = 1'b1;
        ready_random = 1'b0;
        hold_window  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name    = "register operands";
        ready_random = 1'b1;
        for (int i = 0; i < 20; i++) begin
            send_item(random_req(1'b0, 1'b0, size_t'($urandom % 8)));
        end
        wait_drained();

        test_name = "memory operands";
        for (int i = 0; i < 30; i++) begin
            send_item(random_req(1'($urandom % 2), 1'($urandom % 2), size_t'($urandom % 8)));
        end
        wait_drained();

        test_name = "size masking";
        for (int s = 0; s < 8; s++) begin
            send_item(random_req(1'b1, 1'b1, size_t'(s)));
        end
        wait_drained();

        test_name = "dependency hold";
        repeat (2) @(posedge clk);
        #1;
        wb_valid = 1'b0;                    // stores stay pending
        item = random_req(1'b1, 1'b0, SIZE_64);
        item.op0.address.addr = 32'h0000_1000;  // store covers 1000..1007
        send_item(item);
        for (int i = 0; i < 2; i++) begin
            item = random_req(1'b1, 1'b1, SIZE_32);
            item.op0.address.addr = 32'h0000_2000 + 32'(16 * i);
            item.op1.address.addr = 32'h0000_3000;
            send_item(item);
        end
        send_item(random_req(1'b0, 1'b0, SIZE_16));
        item = random_req(1'b0, 1'b1, SIZE_32);
        item.op1.address.addr = 32'h0000_1004;  // inside the pending store
        hold_window = 1'b1;
        fork
            send_item(item);
            begin
                wb_valid     = 1'b1;        // writeback of a register result
                wb_to_memory = 1'b0;
                repeat (10) @(posedge clk);
                #1;
                wb_to_memory = 1'b1;        // memory write not yet taken
                wb_ready     = 1'b0;
                repeat (10) @(posedge clk);
                #1;
                hold_window = 1'b0;
                wb_ready    = 1'b1;         // one pop so the oldest entry leaves
                @(posedge clk);
                #1;
                wb_valid = 1'b0;
            end
        join
        wait_drained();
        wb_valid = 1'b1;

        test_name = "back-pressure and flush";
        repeat (2) @(posedge clk);
        #1;
        wb_valid     = 1'b0;
        ready_random = 1'b0;
        e_ready      = 1'b0;
        item = random_req(1'b1, 1'b0, SIZE_32);
        item.op0.address.addr = 32'h0000_5000;
        send_item(item);
        repeat (5) @(posedge clk);          // held at execute
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush   = 1'b0;
        e_ready = 1'b1;
        send_item(item);                    // same address and no hold after flush
        wait_drained();

        $display(">>> PASS");
        $finish;
    end

endmodule
